// File: project.f
rv_arch_pkg.sv
rv_ctrl_pkg.sv
rv_regfile.sv
rv_alu.sv
rv_pc_unit.sv
rv_decoder.sv
rv_core.sv
tb_rv_core.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_rv_core -f project.f -o tb_rv_core &&
./obj_dir/tb_rv_core | tee /dev/stderr | grep -q "STATUS: PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

  localparam int                 xlen          = 64;
  localparam rv_arch_pkg::addr_t reset_pc      = 64'h8000_0000;
  localparam int                 clk_period_ns = 10;
  localparam int                 reset_cycles  = 16;
  localparam int                 num_runs      = 5;
  localparam int                 insts_per_run = 400;
  // each run ends on a halting word here, the rest runs halted
  localparam int                 halt_index    = 320;
  localparam int                 timeout_ns    = num_runs * insts_per_run * clk_period_ns
                                                 + num_runs * (reset_cycles + 4) * clk_period_ns
                                                 + 2000;

  // opcodes written out from the ISA manual
  localparam logic [6:0] opc_op_imm    = 7'b0010011;
  localparam logic [6:0] opc_op_imm_32 = 7'b0011011;
  localparam logic [6:0] opc_op        = 7'b0110011;
  localparam logic [6:0] opc_op_32     = 7'b0111011;
  localparam logic [6:0] opc_lui       = 7'b0110111;
  localparam logic [6:0] opc_auipc     = 7'b0010111;
  localparam logic [6:0] opc_jal       = 7'b1101111;
  localparam logic [6:0] opc_jalr      = 7'b1100111;
  localparam logic [6:0] opc_branch    = 7'b1100011;
  localparam logic [6:0] opc_load      = 7'b0000011;

  // instruction classes, the first 14 are drawn at random
  localparam int CLS_ADDI    = 0;
  localparam int CLS_SLTIU   = 1;
  localparam int CLS_SRAI    = 2;
  localparam int CLS_ADDIW   = 3;
  localparam int CLS_SLLIW   = 4;
  localparam int CLS_ADD     = 5;
  localparam int CLS_SUB     = 6;
  localparam int CLS_ADDW    = 7;
  localparam int CLS_LUI     = 8;
  localparam int CLS_AUIPC   = 9;
  localparam int CLS_JAL     = 10;
  localparam int CLS_JALR    = 11;
  localparam int CLS_BEQ     = 12;
  localparam int CLS_BGE     = 13;
  localparam int CLS_EBREAK  = 14;
  localparam int CLS_ILLEGAL = 15;

  logic                  clk;
  logic                  reset;
  rv_arch_pkg::inst_t    inst;
  rv_arch_pkg::addr_t    pc;
  logic                  rd_wen;
  rv_arch_pkg::reg_idx_t rd_addr;
  rv_arch_pkg::xlen_t    rd_data;
  logic                  halted;
  logic                  halt_illegal;

  // reference model state
  rv_arch_pkg::xlen_t    model_regs [32];
  rv_arch_pkg::addr_t    model_pc;
  logic                  model_halted;
  logic                  model_illegal;

  // fields of the instruction currently on inst
  int                    cur_cls;
  rv_arch_pkg::reg_idx_t cur_rd;
  rv_arch_pkg::reg_idx_t cur_rs1;
  rv_arch_pkg::reg_idx_t cur_rs2;
  rv_arch_pkg::imm_t     cur_imm;
  logic [5:0]            cur_shamt;
  rv_arch_pkg::inst_t    cur_inst;

  integer                seed;

  rv_core #(.xlen(xlen), .reset_pc(reset_pc)) dut (
    .clk          (clk),
    .reset        (reset),
    .inst         (inst),
    .pc           (pc),
    .rd_wen       (rd_wen),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data),
    .halted       (halted),
    .halt_illegal (halt_illegal)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period_ns / 2) clk = ~clk;
  end

  // hard stop if the stimulus loop stalls
  initial begin
    #(timeout_ns);
    $display("watchdog: simulation did not finish within %0d ns", timeout_ns);
    $display("STATUS: FAIL");
    $fatal(1);
  end

  task automatic report_mismatch(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic check_pc(input rv_arch_pkg::addr_t got, input rv_arch_pkg::addr_t exp);
    if (got !== exp) begin
      report_mismatch($sformatf("pc is %h, expected %h", got, exp));
    end
  endtask

  // addr and data only matter when a write is expected
  task automatic check_write(
    input logic                  got_wen,
    input logic                  exp_wen,
    input rv_arch_pkg::reg_idx_t got_addr,
    input rv_arch_pkg::reg_idx_t exp_addr,
    input rv_arch_pkg::xlen_t    got_data,
    input rv_arch_pkg::xlen_t    exp_data
  );
    if (got_wen !== exp_wen) begin
      report_mismatch($sformatf("rd_wen is %b, expected %b (inst %h)", got_wen, exp_wen,
                                cur_inst));
    end else if (exp_wen && got_addr !== exp_addr) begin
      report_mismatch($sformatf("rd_addr is %0d, expected %0d", got_addr, exp_addr));
    end else if (exp_wen && got_data !== exp_data) begin
      report_mismatch($sformatf("rd_data is %h, expected %h (inst %h)", got_data, exp_data,
                                cur_inst));
    end
  endtask

  task automatic check_halt(
    input logic got_halted,
    input logic exp_halted,
    input logic got_illegal,
    input logic exp_illegal
  );
    if (got_halted !== exp_halted || got_illegal !== exp_illegal) begin
      report_mismatch($sformatf("halted/halt_illegal are %b/%b, expected %b/%b",
                                got_halted, got_illegal, exp_halted, exp_illegal));
    end
  endtask

  function automatic rv_arch_pkg::xlen_t sign_extend_word(input logic [31:0] w);
    return {{(xlen-32){w[31]}}, w};
  endfunction

  function automatic rv_arch_pkg::imm_t sign_extend_imm12(input logic [11:0] v);
    return {{(xlen-12){v[11]}}, v};
  endfunction

  // draws one instruction and records its fields for the model
  task automatic pick_instruction(input int idx, input int run);
    logic [31:0] r0;
    logic [31:0] r1;
    logic [11:0] imm12;
    logic [19:0] imm20;
    logic [20:0] off_j;
    logic [12:0] off_b;
    logic        bad_target;
    r0 = $random(seed);
    r1 = $random(seed);
    // x0 as destination one time in eight
    cur_rd    = (r0[2:0] == 3'd0) ? 5'd0 : r0[7:3];
    cur_rs1   = r0[12:8];
    // equal sources half the time so beq gets taken
    cur_rs2   = r0[13] ? cur_rs1 : r0[18:14];
    cur_shamt = r0[24:19];
    cur_cls   = int'(r0[31:25]) % 14;
    cur_imm   = '0;
    imm12     = r1[11:0];
    imm20     = r1[31:12];
    off_j     = {r1[20:2], 2'b00};
    off_b     = {r1[12:2], 2'b00};
    if (idx == halt_index) begin
      case (run % 5)
        0:       cur_cls = CLS_EBREAK;
        1:       cur_cls = CLS_ILLEGAL;
        2:       cur_cls = CLS_JAL;
        3:       cur_cls = CLS_JALR;
        default: cur_cls = CLS_BEQ;
      endcase
    end
    bad_target = (idx == halt_index);
    // jalr from x0, bit 0 of the offset is cleared by the core
    if (cur_cls == CLS_JALR) begin
      cur_rs1  = 5'd0;
      imm12[1] = bad_target;
    end
    if (bad_target) begin
      off_j[1] = 1'b1;
      off_b[1] = 1'b1;
      if (cur_cls == CLS_BEQ) begin
        cur_rs1 = 5'd0;
        cur_rs2 = 5'd0;
      end
    end
    case (cur_cls)
      CLS_ADDI: begin
        cur_imm  = sign_extend_imm12(imm12);
        cur_inst = {imm12, cur_rs1, 3'b000, cur_rd, opc_op_imm};
      end
      CLS_SLTIU: begin
        cur_imm  = sign_extend_imm12(imm12);
        cur_inst = {imm12, cur_rs1, 3'b011, cur_rd, opc_op_imm};
      end
      CLS_SRAI:  cur_inst = {6'b010000, cur_shamt, cur_rs1, 3'b101, cur_rd, opc_op_imm};
      CLS_ADDIW: begin
        cur_imm  = sign_extend_imm12(imm12);
        cur_inst = {imm12, cur_rs1, 3'b000, cur_rd, opc_op_imm_32};
      end
      CLS_SLLIW: begin
        cur_inst = {7'b0000000, cur_shamt[4:0], cur_rs1, 3'b001, cur_rd, opc_op_imm_32};
      end
      CLS_ADD:   cur_inst = {7'b0000000, cur_rs2, cur_rs1, 3'b000, cur_rd, opc_op};
      CLS_SUB:   cur_inst = {7'b0100000, cur_rs2, cur_rs1, 3'b000, cur_rd, opc_op};
      CLS_ADDW:  cur_inst = {7'b0000000, cur_rs2, cur_rs1, 3'b000, cur_rd, opc_op_32};
      CLS_LUI, CLS_AUIPC: begin
        cur_imm  = {{(xlen-32){imm20[19]}}, imm20, 12'b0};
        cur_inst = {imm20, cur_rd, (cur_cls == CLS_LUI) ? opc_lui : opc_auipc};
      end
      CLS_JAL: begin
        cur_imm  = {{(xlen-21){off_j[20]}}, off_j};
        cur_inst = {off_j[20], off_j[10:1], off_j[11], off_j[19:12], cur_rd, opc_jal};
      end
      CLS_JALR: begin
        cur_imm  = sign_extend_imm12(imm12);
        cur_inst = {imm12, cur_rs1, 3'b000, cur_rd, opc_jalr};
      end
      CLS_BEQ, CLS_BGE: begin
        cur_imm  = {{(xlen-13){off_b[12]}}, off_b};
        cur_inst = {off_b[12], off_b[10:5], cur_rs2, cur_rs1,
                    (cur_cls == CLS_BEQ) ? 3'b000 : 3'b101, off_b[4:1], off_b[11], opc_branch};
      end
      CLS_EBREAK: cur_inst = 32'h0010_0073;
      // a load, or sll which this core leaves out
      default: begin
        cur_inst = r1[0] ? {r1[31:7], opc_load}
                         : {7'b0000000, cur_rs2, cur_rs1, 3'b001, cur_rd, opc_op};
      end
    endcase
  endtask

  // predicts the outputs for cur_inst, checks them, then retires in the model
  task automatic check_and_retire();
    rv_arch_pkg::xlen_t a;
    rv_arch_pkg::xlen_t b;
    rv_arch_pkg::xlen_t value;
    rv_arch_pkg::addr_t target;
    logic               writes;
    logic               fault;
    logic               is_break;
    logic               exp_wen;
    a        = model_regs[cur_rs1];
    b        = model_regs[cur_rs2];
    value    = '0;
    target   = model_pc + 64'd4;
    writes   = 1'b1;
    fault    = 1'b0;
    is_break = 1'b0;
    case (cur_cls)
      CLS_ADDI:  value = a + cur_imm;
      CLS_SLTIU: value = (a < cur_imm) ? 64'd1 : 64'd0;
      CLS_SRAI:  value = $signed(a) >>> cur_shamt;
      CLS_ADDIW: value = sign_extend_word(a[31:0] + cur_imm[31:0]);
      CLS_SLLIW: value = sign_extend_word(a[31:0] << cur_shamt[4:0]);
      CLS_ADD:   value = a + b;
      CLS_SUB:   value = a - b;
      CLS_ADDW:  value = sign_extend_word(a[31:0] + b[31:0]);
      CLS_LUI:   value = cur_imm;
      CLS_AUIPC: value = model_pc + cur_imm;
      CLS_JAL: begin
        value  = model_pc + 64'd4;
        target = model_pc + cur_imm;
      end
      CLS_JALR: begin
        value  = model_pc + 64'd4;
        target = (a + cur_imm) & ~64'd1;
      end
      CLS_BEQ: begin
        writes = 1'b0;
        if (a == b) begin
          target = model_pc + cur_imm;
        end
      end
      CLS_BGE: begin
        writes = 1'b0;
        if ($signed(a) >= $signed(b)) begin
          target = model_pc + cur_imm;
        end
      end
      CLS_EBREAK: begin
        writes   = 1'b0;
        is_break = 1'b1;
      end
      default: begin
        writes = 1'b0;
        fault  = 1'b1;
      end
    endcase
    if (target[1:0] != 2'b00) begin
      fault = 1'b1;
    end
    exp_wen = !model_halted && !fault && !is_break && writes && (cur_rd != 5'd0);
    check_halt(halted, model_halted, halt_illegal, model_illegal);
    check_pc(pc, model_pc);
    check_write(rd_wen, exp_wen, rd_addr, cur_rd, rd_data, value);
    // halted model keeps pc and registers
    if (!model_halted) begin
      if (fault) begin
        model_halted  = 1'b1;
        model_illegal = 1'b1;
      end else if (is_break) begin
        model_halted = 1'b1;
      end else begin
        if (exp_wen) begin
          model_regs[cur_rd] = value;
        end
        model_pc = target;
      end
    end
  endtask

  // leaves the caller on the posedge where reset drops
  task automatic apply_reset();
    reset <= 1'b1;
    inst  <= '0;
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;
    for (int k = 0; k < 32; k++) begin
      model_regs[k] = '0;
    end
    model_pc      = reset_pc;
    model_halted  = 1'b0;
    model_illegal = 1'b0;
  endtask

  initial begin
    seed  = 32'h492c;
    reset = 1'b1;
    inst  = '0;
    for (int run = 0; run < num_runs; run++) begin
      apply_reset();
      for (int idx = 0; idx < insts_per_run; idx++) begin
        pick_instruction(idx, run);
        inst <= cur_inst;
        // outputs are settled half a cycle after the drive
        @(negedge clk);
        check_and_retire();
        @(posedge clk);
      end
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
  parameter int                 xlen     = rv_arch_pkg::XLEN,
  parameter rv_arch_pkg::addr_t reset_pc = 64'h8000_0000
) (
  input  wire                          clk,
  input  wire                          reset,
  input  wire rv_arch_pkg::inst_t      inst,
  output rv_arch_pkg::addr_t           pc,
  output logic                         rd_wen,
  output rv_arch_pkg::reg_idx_t        rd_addr,
  output rv_arch_pkg::xlen_t           rd_data,
  output logic                         halted,
  output logic                         halt_illegal
);

  rv_arch_pkg::reg_idx_t    rs1;
  rv_arch_pkg::reg_idx_t    rs2;
  rv_arch_pkg::imm_t        imm;
  rv_arch_pkg::xlen_t       rs1_data;
  rv_arch_pkg::xlen_t       rs2_data;
  rv_ctrl_pkg::alu_op_e     alu_op;
  rv_ctrl_pkg::src_a_e      src_a_sel;
  rv_ctrl_pkg::src_b_e      src_b_sel;
  rv_ctrl_pkg::pc_sel_e     pc_sel;
  logic                     branch_ge;
  logic                     commit;
  logic                     misaligned;

  // control: decode, immediates and run/halt state
  rv_decoder #(.xlen(xlen)) u_decoder (
    .clk          (clk),
    .reset        (reset),
    .inst         (inst),
    .misaligned   (misaligned),
    .rs1          (rs1),
    .rs2          (rs2),
    .rd           (rd_addr),
    .imm          (imm),
    .alu_op       (alu_op),
    .src_a_sel    (src_a_sel),
    .src_b_sel    (src_b_sel),
    .pc_sel       (pc_sel),
    .branch_ge    (branch_ge),
    .commit       (commit),
    .rd_wen       (rd_wen),
    .halted       (halted),
    .halt_illegal (halt_illegal)
  );

  // write port takes the alu result, which is also the visible rd_data
  rv_regfile #(.xlen(xlen)) u_regfile (
    .clk      (clk),
    .reset    (reset),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd_addr),
    .wen      (rd_wen),
    .wdata    (rd_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_alu #(.xlen(xlen)) u_alu (
    .alu_op    (alu_op),
    .src_a_sel (src_a_sel),
    .src_b_sel (src_b_sel),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .pc        (pc),
    .imm       (imm),
    .result    (rd_data)
  );

  rv_pc_unit #(.xlen(xlen), .reset_pc(reset_pc)) u_pc_unit (
    .clk        (clk),
    .reset      (reset),
    .commit     (commit),
    .pc_sel     (pc_sel),
    .branch_ge  (branch_ge),
    .imm        (imm),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .pc         (pc),
    .misaligned (misaligned)
  );

endmodule

`default_nettype wire

// File: rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder #(
  parameter int xlen = rv_arch_pkg::XLEN
) (
  input  wire                        clk,
  input  wire                        reset,
  input  wire rv_arch_pkg::inst_t    inst,
  input  wire                        misaligned,
  output rv_arch_pkg::reg_idx_t      rs1,
  output rv_arch_pkg::reg_idx_t      rs2,
  output rv_arch_pkg::reg_idx_t      rd,
  output rv_arch_pkg::imm_t          imm,
  output rv_ctrl_pkg::alu_op_e       alu_op,
  output rv_ctrl_pkg::src_a_e        src_a_sel,
  output rv_ctrl_pkg::src_b_e        src_b_sel,
  output rv_ctrl_pkg::pc_sel_e       pc_sel,
  output logic                       branch_ge,
  output logic                       commit,
  output logic                       rd_wen,
  output logic                       halted,
  output logic                       halt_illegal
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  rv_arch_pkg::imm_t imm_i;
  rv_arch_pkg::imm_t imm_u;
  rv_arch_pkg::imm_t imm_b;
  rv_arch_pkg::imm_t imm_j;
  logic legal;
  logic is_ebreak;
  logic reg_wen_req;
  rv_ctrl_pkg::core_state_e state;
  rv_ctrl_pkg::core_state_e state_next;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign rd     = inst[11:7];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];

  // immediate formats, all sign-extended from inst[31]
  assign imm_i = {{(xlen-12){inst[31]}}, inst[31:20]};
  assign imm_u = {{(xlen-32){inst[31]}}, inst[31:12], 12'b0};
  assign imm_b = {{(xlen-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_j = {{(xlen-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // pattern match; anything not claimed below stays illegal
  always_comb begin
    legal       = 1'b0;
    is_ebreak   = 1'b0;
    reg_wen_req = 1'b0;
    imm         = imm_i;
    alu_op      = rv_ctrl_pkg::ALU_ADD;
    src_a_sel   = rv_ctrl_pkg::SRC_A_RS1;
    src_b_sel   = rv_ctrl_pkg::SRC_B_IMM;
    pc_sel      = rv_ctrl_pkg::PC_SEQ;
    branch_ge   = 1'b0;
    case (opcode)
      rv_arch_pkg::OP_IMM: begin
        reg_wen_req = 1'b1;
        case (funct3)
          rv_arch_pkg::F3_ADD: legal = 1'b1;
          rv_arch_pkg::F3_SLTU: begin
            legal  = 1'b1;
            alu_op = rv_ctrl_pkg::ALU_SLTU;
          end
          // srai: top six bits fixed, shamt sits in imm[5:0]
          rv_arch_pkg::F3_SR: begin
            legal  = (funct7[6:1] == rv_arch_pkg::F7_ALT[6:1]);
            alu_op = rv_ctrl_pkg::ALU_SRA;
          end
          default: ;
        endcase
      end
      rv_arch_pkg::OP_IMM_32: begin
        reg_wen_req = 1'b1;
        case (funct3)
          rv_arch_pkg::F3_ADD: begin
            legal  = 1'b1;
            alu_op = rv_ctrl_pkg::ALU_ADD_W;
          end
          rv_arch_pkg::F3_SLL: begin
            legal  = (funct7 == rv_arch_pkg::F7_BASE);
            alu_op = rv_ctrl_pkg::ALU_SLL_W;
          end
          default: ;
        endcase
      end
      rv_arch_pkg::OP: begin
        reg_wen_req = 1'b1;
        src_b_sel   = rv_ctrl_pkg::SRC_B_RS2;
        if (funct3 == rv_arch_pkg::F3_ADD && funct7 == rv_arch_pkg::F7_BASE) begin
          legal = 1'b1;
        end else if (funct3 == rv_arch_pkg::F3_ADD && funct7 == rv_arch_pkg::F7_ALT) begin
          legal  = 1'b1;
          alu_op = rv_ctrl_pkg::ALU_SUB;
        end
      end
      // only addw among the word register ops
      rv_arch_pkg::OP_32: begin
        reg_wen_req = 1'b1;
        src_b_sel   = rv_ctrl_pkg::SRC_B_RS2;
        alu_op      = rv_ctrl_pkg::ALU_ADD_W;
        legal       = (funct3 == rv_arch_pkg::F3_ADD && funct7 == rv_arch_pkg::F7_BASE);
      end
      rv_arch_pkg::LUI: begin
        legal       = 1'b1;
        reg_wen_req = 1'b1;
        imm         = imm_u;
        src_a_sel   = rv_ctrl_pkg::SRC_A_ZERO;
      end
      rv_arch_pkg::AUIPC: begin
        legal       = 1'b1;
        reg_wen_req = 1'b1;
        imm         = imm_u;
        src_a_sel   = rv_ctrl_pkg::SRC_A_PC;
      end
      // jumps write the link value pc + 4 through the alu
      rv_arch_pkg::JAL: begin
        legal       = 1'b1;
        reg_wen_req = 1'b1;
        imm         = imm_j;
        src_a_sel   = rv_ctrl_pkg::SRC_A_PC;
        src_b_sel   = rv_ctrl_pkg::SRC_B_FOUR;
        pc_sel      = rv_ctrl_pkg::PC_JAL;
      end
      rv_arch_pkg::JALR: begin
        legal       = (funct3 == rv_arch_pkg::F3_JALR);
        reg_wen_req = 1'b1;
        src_a_sel   = rv_ctrl_pkg::SRC_A_PC;
        src_b_sel   = rv_ctrl_pkg::SRC_B_FOUR;
        pc_sel      = rv_ctrl_pkg::PC_JALR;
      end
      rv_arch_pkg::BRANCH: begin
        imm    = imm_b;
        pc_sel = rv_ctrl_pkg::PC_BRANCH;
        case (funct3)
          rv_arch_pkg::F3_BEQ: legal = 1'b1;
          rv_arch_pkg::F3_BGE: begin
            legal     = 1'b1;
            branch_ge = 1'b1;
          end
          default: ;
        endcase
      end
      rv_arch_pkg::SYSTEM: begin
        is_ebreak = (inst == rv_arch_pkg::EBREAK);
        legal     = is_ebreak;
      end
      default: ;
    endcase
  end

  // ebreak and faulting words retire nothing
  assign commit = (state == rv_ctrl_pkg::ST_RUN) && legal && !is_ebreak && !misaligned;
  assign rd_wen = commit && reg_wen_req && (rd != '0);

  assign halted       = (state != rv_ctrl_pkg::ST_RUN);
  assign halt_illegal = (state == rv_ctrl_pkg::ST_HALT_ILLEGAL);

  // halt states are sticky until reset
  always_comb begin
    state_next = state;
    if (state == rv_ctrl_pkg::ST_RUN) begin
      if (!legal || misaligned) begin
        state_next = rv_ctrl_pkg::ST_HALT_ILLEGAL;
      end else if (is_ebreak) begin
        state_next = rv_ctrl_pkg::ST_HALT_EBREAK;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= rv_ctrl_pkg::ST_RUN;
    end else begin
      state <= state_next;
    end
  end

  // a stopped core never leaves its halt state on its own
  assert property (@(posedge clk) disable iff (reset) halted |=> $stable(state));

  // a retired instruction always leaves the core running
  assert property (@(posedge clk) disable iff (reset) commit |=> !halted);

endmodule

`default_nettype wire

// File: rv_pc_unit.sv
`timescale 1ns/1ps
`default_nettype none

module rv_pc_unit #(
  parameter int                 xlen     = rv_arch_pkg::XLEN,
  parameter rv_arch_pkg::addr_t reset_pc = 64'h8000_0000
) (
  input  wire                          clk,
  input  wire                          reset,
  input  wire                          commit,
  input  wire rv_ctrl_pkg::pc_sel_e    pc_sel,
  input  wire                          branch_ge,
  input  wire rv_arch_pkg::imm_t       imm,
  input  wire rv_arch_pkg::xlen_t      rs1_data,
  input  wire rv_arch_pkg::xlen_t      rs2_data,
  output rv_arch_pkg::addr_t           pc,
  output logic                         misaligned
);

  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] pc_plus_imm;
  logic [xlen-1:0] jalr_target;
  logic [xlen-1:0] next_pc;
  logic            taken;

  // bge is signed, beq is plain equality
  assign taken = branch_ge ? ($signed(rs1_data) >= $signed(rs2_data)) : (rs1_data == rs2_data);

  assign pc_plus4    = pc + {{(xlen-3){1'b0}}, 3'd4};
  assign pc_plus_imm = pc + imm;
  // jalr clears bit 0 only, bit 1 can still fault
  assign jalr_target = (rs1_data + imm) & ~{{(xlen-1){1'b0}}, 1'b1};

  always_comb begin
    case (pc_sel)
      rv_ctrl_pkg::PC_JAL:    next_pc = pc_plus_imm;
      rv_ctrl_pkg::PC_JALR:   next_pc = jalr_target;
      rv_ctrl_pkg::PC_BRANCH: next_pc = taken ? pc_plus_imm : pc_plus4;
      default:                next_pc = pc_plus4;
    endcase
  end

  assign misaligned = (next_pc[1:0] != 2'b00);

  // pc only moves on a committed instruction
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= reset_pc;
    end else if (commit) begin
      pc <= next_pc;
    end
  end

  // decoder must block a commit to any unaligned target
  assert property (@(posedge clk) disable iff (reset) commit |=> pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu #(
  parameter int xlen = rv_arch_pkg::XLEN
) (
  input  wire rv_ctrl_pkg::alu_op_e  alu_op,
  input  wire rv_ctrl_pkg::src_a_e   src_a_sel,
  input  wire rv_ctrl_pkg::src_b_e   src_b_sel,
  input  wire rv_arch_pkg::xlen_t    rs1_data,
  input  wire rv_arch_pkg::xlen_t    rs2_data,
  input  wire rv_arch_pkg::addr_t    pc,
  input  wire rv_arch_pkg::imm_t     imm,
  output rv_arch_pkg::xlen_t         result
);

  // full-width shift amount, word forms use one bit less
  localparam int shamt_w = $clog2(xlen);

  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [xlen-1:0] sum;
  logic [xlen-1:0] diff;
  logic [31:0]     word;

  // operand muxes
  always_comb begin
    case (src_a_sel)
      rv_ctrl_pkg::SRC_A_PC:   op_a = pc;
      rv_ctrl_pkg::SRC_A_ZERO: op_a = '0;
      default:                 op_a = rs1_data;
    endcase
    case (src_b_sel)
      rv_ctrl_pkg::SRC_B_RS2:  op_b = rs2_data;
      rv_ctrl_pkg::SRC_B_FOUR: op_b = {{(xlen-3){1'b0}}, 3'd4};
      default:                 op_b = imm;
    endcase
  end

  // one adder and one subtractor shared by full and word forms
  assign sum  = op_a + op_b;
  assign diff = op_a - op_b;

  always_comb begin
    word = sum[31:0];
    case (alu_op)
      rv_ctrl_pkg::ALU_ADD:  result = sum;
      rv_ctrl_pkg::ALU_SUB:  result = diff;
      // unsigned compare, 1 or 0
      rv_ctrl_pkg::ALU_SLTU: result = {{(xlen-1){1'b0}}, op_a < op_b};
      rv_ctrl_pkg::ALU_SRA:  result = $signed(op_a) >>> op_b[shamt_w-1:0];
      default: begin
        // word forms work on the low half, then sign-extend bit 31
        if (alu_op == rv_ctrl_pkg::ALU_SUB_W) begin
          word = diff[31:0];
        end else if (alu_op == rv_ctrl_pkg::ALU_SLL_W) begin
          word = op_a[31:0] << op_b[4:0];
        end
        result = {{(xlen-32){word[31]}}, word};
      end
    endcase
    // upper half of a word result mirrors bit 31
    if (alu_op inside {rv_ctrl_pkg::ALU_ADD_W, rv_ctrl_pkg::ALU_SUB_W,
                       rv_ctrl_pkg::ALU_SLL_W}) begin
      assert (result[xlen-1:32] == {(xlen-32){result[31]}});
    end
  end

endmodule

`default_nettype wire

// File: rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile #(
  parameter int xlen = rv_arch_pkg::XLEN
) (
  input  wire                          clk,
  input  wire                          reset,
  input  wire rv_arch_pkg::reg_idx_t   rs1,
  input  wire rv_arch_pkg::reg_idx_t   rs2,
  input  wire rv_arch_pkg::reg_idx_t   rd,
  input  wire                          wen,
  input  wire rv_arch_pkg::xlen_t      wdata,
  output rv_arch_pkg::xlen_t           rs1_data,
  output rv_arch_pkg::xlen_t           rs2_data
);

  // x0 is kept as a real entry that is only ever cleared
  logic [xlen-1:0] regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      regs <= '{default: '0};
    end else if (wen && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // asynchronous read, a write lands for the next cycle
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  // x0 survives every write edge
  assert property (@(posedge clk) disable iff (reset) wen |=> regs[0] == '0);

endmodule

`default_nettype wire

// File: rv_ctrl_pkg.sv
`default_nettype none

// control encodings shared between the decoder and the datapath
package rv_ctrl_pkg;

  // operation performed by the alu
  typedef enum logic [2:0] {
    ALU_ADD   = 3'd0,
    ALU_SUB   = 3'd1,
    ALU_SLTU  = 3'd2,
    ALU_SRA   = 3'd3,
    // word forms, result sign-extended from bit 31
    ALU_ADD_W = 3'd4,
    ALU_SUB_W = 3'd5,
    ALU_SLL_W = 3'd6
  } alu_op_e;

  // first operand source
  typedef enum logic [1:0] {
    SRC_A_RS1  = 2'd0,
    SRC_A_PC   = 2'd1,
    SRC_A_ZERO = 2'd2
  } src_a_e;

  // second operand source, four is the link offset for jumps
  typedef enum logic [1:0] {
    SRC_B_RS2  = 2'd0,
    SRC_B_IMM  = 2'd1,
    SRC_B_FOUR = 2'd2
  } src_b_e;

  // next pc choice
  typedef enum logic [1:0] {
    PC_SEQ    = 2'd0,
    PC_JAL    = 2'd1,
    PC_JALR   = 2'd2,
    PC_BRANCH = 2'd3
  } pc_sel_e;

  // run/halt state
  typedef enum logic [1:0] {
    ST_RUN          = 2'd0,
    ST_HALT_EBREAK  = 2'd1,
    ST_HALT_ILLEGAL = 2'd2
  } core_state_e;

endpackage

`default_nettype wire

// File: rv_arch_pkg.sv
`default_nettype none

// RV64I architectural widths, encodings and vector types
package rv_arch_pkg;

  // register width, default for every module's xlen parameter
  parameter int XLEN = 64;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [31:0]     inst_t;
  typedef logic [4:0]      reg_idx_t;
  typedef logic [XLEN-1:0] addr_t;
  // immediates are always carried sign-extended to full width
  typedef logic [XLEN-1:0] imm_t;

  // major opcodes, inst[6:0]
  parameter logic [6:0] OP_IMM    = 7'b0010011;
  parameter logic [6:0] OP_IMM_32 = 7'b0011011;
  parameter logic [6:0] OP        = 7'b0110011;
  parameter logic [6:0] OP_32     = 7'b0111011;
  parameter logic [6:0] LUI       = 7'b0110111;
  parameter logic [6:0] AUIPC     = 7'b0010111;
  parameter logic [6:0] JAL       = 7'b1101111;
  parameter logic [6:0] JALR      = 7'b1100111;
  parameter logic [6:0] BRANCH    = 7'b1100011;
  parameter logic [6:0] SYSTEM    = 7'b1110011;

  // funct3, inst[14:12]
  parameter logic [2:0] F3_ADD  = 3'b000;
  parameter logic [2:0] F3_SLL  = 3'b001;
  parameter logic [2:0] F3_SLTU = 3'b011;
  parameter logic [2:0] F3_SR   = 3'b101;
  parameter logic [2:0] F3_JALR = 3'b000;
  parameter logic [2:0] F3_BEQ  = 3'b000;
  parameter logic [2:0] F3_BGE  = 3'b101;

  // funct7, inst[31:25]; alt selects sub and arithmetic shift
  parameter logic [6:0] F7_BASE = 7'b0000000;
  parameter logic [6:0] F7_ALT  = 7'b0100000;

  // the one SYSTEM word the core accepts
  parameter inst_t EBREAK = 32'h0010_0073;

endpackage

`default_nettype wire
